//--- album_geom_pkg.sv
package album_geom_pkg;

    // image memory side
    typedef logic [19:0] im_addr_t;    // word address into image memory
    typedef logic [23:0] pixel_t;      // rgb word, also the header word width

    // character rom side
    typedef logic [8:0]  cr_addr_t;    // 11 glyphs x 24 rows fits in 9 bits
    typedef logic [12:0] glyph_row_t;  // one font row, msb is the leftmost pixel

    // font cell size
    localparam int GLYPH_W = 13;
    localparam int GLYPH_H = 24;       // rom rows per glyph

    // frame layout, 256 pixels per line
    localparam int LINE_STRIDE = 256;
    // overlay origin: row 232, col 152 from fb base
    localparam im_addr_t TEXT_OFFSET = 20'd59544;
    localparam int NUM_CHARS = 8;      // hh:mm:ss

    // pixel colours
    localparam pixel_t PIX_ON  = 24'hFF_FFFF;  // white
    localparam pixel_t PIX_OFF = 24'h00_0000;  // black

    // header words at the bottom of image memory
    localparam im_addr_t HDR_TIME_ADDR = 20'd0;  // start time, hh mm ss bytes
    localparam im_addr_t HDR_FB_ADDR   = 20'd1;  // frame buffer base

endpackage

//--- album_time_pkg.sv
package album_time_pkg;

    // one binary time field, hour / minute / second
    typedef logic [7:0] time_field_t;

    // single decimal digit
    typedef logic [3:0] bcd_t;

    // glyph number in the character rom
    // 0..9 are the digits, 10 is the colon
    typedef logic [3:0] glyph_idx_t;

    localparam glyph_idx_t GLYPH_COLON = 4'd10;

    // rom fetch fsm
    //   IDLE  waiting for a redraw request
    //   ADDR  rom address goes out
    //   DATA  rom read in progress
    //   HOLD  rom data valid, waiting for the row register to free up
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        HOLD
    } fetch_state_t;

    // header time word layout: hh in [23:16], mm in [15:8], ss in [7:0]

endpackage

//--- image_port.sv
`timescale 1ns/1ps

module image_port
    import album_geom_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pixel_t   im_q,        // data for last cycle's im_a
    input  logic     wr_en,       // write request from pixel writer
    input  im_addr_t wr_addr,
    input  pixel_t   wr_data,
    output im_addr_t im_a,
    output pixel_t   im_d,
    output logic     im_wen,      // active low
    output pixel_t   start_time,  // header word 0
    output im_addr_t fb_base,     // header word 1, held after header
    output logic     hdr_done     // one cycle pulse
);

    logic [1:0] hdr_cnt;   // 0,1,2 header phase, 3 = forwarding writes
    logic       hdr_busy;

    assign hdr_busy = (hdr_cnt != 2'd3);

    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_cnt  <= 2'd0;
            im_a     <= HDR_TIME_ADDR;  // first header read already on the bus
            im_wen   <= 1'b1;
            hdr_done <= 1'b0;
        end else begin
            hdr_done <= 1'b0;
            if (hdr_busy) begin
                hdr_cnt <= hdr_cnt + 2'd1;
                if (hdr_cnt == 2'd0)
                    im_a <= HDR_FB_ADDR;  // second header read
                if (hdr_cnt == 2'd2)
                    hdr_done <= 1'b1;     // fb base lands this edge
            end else begin
                im_wen <= ~wr_en;         // low only for a real write
                if (wr_en)
                    im_a <= wr_addr;
            end
        end
    end

    // header capture and write data, one cycle behind the address
    always_ff @(posedge clk) begin
        if (hdr_cnt == 2'd1)
            start_time <= im_q;                       // word at addr 0
        if (hdr_cnt == 2'd2)
            fb_base <= im_q[$bits(im_addr_t)-1:0];    // word at addr 1
        if (!hdr_busy && wr_en)
            im_d <= wr_data;
    end

endmodule

//--- rtc_counter.sv
`timescale 1ns/1ps

module rtc_counter
    import album_geom_pkg::*, album_time_pkg::*;
#(
    parameter int TICKS_PER_SEC = 4096
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        hdr_done,    // load strobe
    input  pixel_t      start_time,  // hh mm ss packed in bytes
    output time_field_t hour,
    output time_field_t minute,
    output time_field_t second,
    output logic        sec_tick     // same edge as the time update
);

    localparam int DIV_W = $clog2(TICKS_PER_SEC);

    logic [DIV_W-1:0] div_cnt;
    logic             running;   // set once the start time is loaded
    logic             div_wrap;

    assign div_wrap = running && (div_cnt == DIV_W'(TICKS_PER_SEC - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt  <= '0;
            running  <= 1'b0;
            sec_tick <= 1'b0;
            hour     <= '0;
            minute   <= '0;
            second   <= '0;
        end else begin
            sec_tick <= 1'b0;
            if (hdr_done) begin
                // restart the divider so the first tick is a full second away
                div_cnt <= '0;
                running <= 1'b1;
                hour    <= start_time[23:16];
                minute  <= start_time[15:8];
                second  <= start_time[7:0];
            end else if (div_wrap) begin
                div_cnt  <= '0;
                sec_tick <= 1'b1;
                if (second == 8'd59) begin
                    second <= '0;
                    if (minute == 8'd59) begin
                        minute <= '0;
                        hour   <= (hour == 8'd23) ? 8'd0 : hour + 8'd1;  // midnight
                    end else begin
                        minute <= minute + 8'd1;
                    end
                end else begin
                    second <= second + 8'd1;
                end
            end else if (running) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- glyph_fetcher.sv
`timescale 1ns/1ps

module glyph_fetcher
    import album_geom_pkg::*, album_time_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        hdr_done,   // first redraw request
    input  logic        sec_tick,   // later redraw requests
    input  time_field_t hour,
    input  time_field_t minute,
    input  time_field_t second,
    input  glyph_row_t  cr_q,       // rom data, one cycle after cr_a
    output cr_addr_t    cr_a,
    output glyph_row_t  row_bits,
    output logic [2:0]  row_char,   // character position 0..7
    output logic [4:0]  row_line,   // row inside the glyph 0..23
    output logic        row_valid,
    input  logic        row_ready
);

    fetch_state_t state;
    logic         pend;                 // one redraw request held
    glyph_idx_t   glyphs [NUM_CHARS];   // time snapshot as glyph numbers
    logic [2:0]   char_cnt;
    logic [4:0]   line_cnt;
    glyph_idx_t   cur_glyph;
    cr_addr_t     rom_addr;
    logic         start;
    logic         last_line;
    logic         last_row;
    logic         load;                 // rom data moves into the row register

    function automatic bcd_t bcd_tens(input time_field_t v);
        return bcd_t'(v / 8'd10);
    endfunction

    function automatic bcd_t bcd_ones(input time_field_t v);
        return bcd_t'(v % 8'd10);
    endfunction

    assign cur_glyph = glyphs[char_cnt];
    assign rom_addr  = cr_addr_t'(cur_glyph) * cr_addr_t'(GLYPH_H) + cr_addr_t'(line_cnt);
    assign start     = (state == IDLE) && pend;
    assign last_line = (line_cnt == 5'(GLYPH_H - 1));
    assign last_row  = last_line && (char_cnt == 3'(NUM_CHARS - 1));
    assign load      = (state == HOLD) && (!row_valid || row_ready);  // free or leaving

    // request flag, a new request wins over the clear
    always_ff @(posedge clk) begin
        if (reset)
            pend <= 1'b0;
        else if (hdr_done || sec_tick)
            pend <= 1'b1;
        else if (start)
            pend <= 1'b0;
    end

    // time is already updated by the cycle pend is seen
    always_ff @(posedge clk) begin
        if (start) begin
            glyphs[0] <= bcd_tens(hour);
            glyphs[1] <= bcd_ones(hour);
            glyphs[2] <= GLYPH_COLON;
            glyphs[3] <= bcd_tens(minute);
            glyphs[4] <= bcd_ones(minute);
            glyphs[5] <= GLYPH_COLON;
            glyphs[6] <= bcd_tens(second);
            glyphs[7] <= bcd_ones(second);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            char_cnt  <= '0;
            line_cnt  <= '0;
            cr_a      <= '0;
            row_valid <= 1'b0;
        end else begin
            if (load)
                row_valid <= 1'b1;
            else if (row_ready)
                row_valid <= 1'b0;  // taken by the writer
            case (state)
                IDLE: begin
                    if (pend) begin
                        char_cnt <= '0;
                        line_cnt <= '0;
                        state    <= ADDR;
                    end
                end
                ADDR: begin
                    cr_a  <= rom_addr;  // glyph * 24 + line
                    state <= DATA;
                end
                DATA: state <= HOLD;    // rom read in flight
                HOLD: begin
                    if (load) begin
                        if (last_line) begin
                            line_cnt <= '0;
                            char_cnt <= char_cnt + 3'd1;
                        end else begin
                            line_cnt <= line_cnt + 5'd1;
                        end
                        state <= last_row ? IDLE : ADDR;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // row payload, stable while row_valid waits
    always_ff @(posedge clk) begin
        if (load) begin
            row_bits <= cr_q;
            row_char <= char_cnt;
            row_line <= line_cnt;
        end
    end

endmodule

//--- pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer
    import album_geom_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  im_addr_t   fb_base,
    input  glyph_row_t row_bits,
    input  logic [2:0] row_char,
    input  logic [4:0] row_line,
    input  logic       row_valid,
    output logic       row_ready,
    output logic       wr_en,     // one pixel write per cycle
    output im_addr_t   wr_addr,
    output pixel_t     wr_data
);

    glyph_row_t shift_q;    // current pixel sits in the msb
    logic [3:0] col_cnt;    // column inside the row, 0..12
    logic       last_col;
    logic       accept;
    im_addr_t   row_start;

    assign last_col  = (col_cnt == 4'(GLYPH_W - 1));
    assign row_ready = !wr_en || last_col;  // idle, or finishing the row
    assign accept    = row_valid && row_ready;

    // first pixel of the row in the frame buffer
    assign row_start = fb_base + TEXT_OFFSET
                     + im_addr_t'(row_char) * im_addr_t'(GLYPH_W)
                     + im_addr_t'(row_line) * im_addr_t'(LINE_STRIDE);

    assign wr_data = shift_q[GLYPH_W-1] ? PIX_ON : PIX_OFF;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en   <= 1'b0;
            col_cnt <= '0;
        end else if (accept) begin
            wr_en   <= 1'b1;  // back to back rows keep wr_en high
            col_cnt <= '0;
        end else if (wr_en) begin
            if (last_col)
                wr_en <= 1'b0;
            else
                col_cnt <= col_cnt + 4'd1;
        end
    end

    // address walk and bit shift
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= row_start;
            shift_q <= row_bits;
        end else if (wr_en) begin
            wr_addr <= wr_addr + im_addr_t'(1);  // next column
            shift_q <= shift_q << 1;
        end
    end

endmodule

//--- photo_clock_top.sv
`timescale 1ns/1ps

module photo_clock_top
    import album_geom_pkg::*, album_time_pkg::*;
#(
    parameter int TICKS_PER_SEC = 4096  // clock cycles per second
) (
    input  logic       clk,
    input  logic       reset,
    input  pixel_t     im_q,
    input  glyph_row_t cr_q,
    output im_addr_t   im_a,
    output pixel_t     im_d,
    output logic       im_wen,
    output cr_addr_t   cr_a
);

    // header stage outputs
    pixel_t      start_time;
    im_addr_t    fb_base;
    logic        hdr_done;
    // time stage
    time_field_t hour;
    time_field_t minute;
    time_field_t second;
    logic        sec_tick;
    // glyph row handshake
    glyph_row_t  row_bits;
    logic [2:0]  row_char;
    logic [4:0]  row_line;
    logic        row_valid;
    logic        row_ready;
    // pixel writes back to the port
    logic        wr_en;
    im_addr_t    wr_addr;
    pixel_t      wr_data;

    image_port image_port_i (
        .clk        (clk),
        .reset      (reset),
        .im_q       (im_q),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .im_a       (im_a),
        .im_d       (im_d),
        .im_wen     (im_wen),
        .start_time (start_time),
        .fb_base    (fb_base),
        .hdr_done   (hdr_done)
    );

    rtc_counter #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) rtc_counter_i (
        .clk        (clk),
        .reset      (reset),
        .hdr_done   (hdr_done),
        .start_time (start_time),
        .hour       (hour),
        .minute     (minute),
        .second     (second),
        .sec_tick   (sec_tick)
    );

    glyph_fetcher glyph_fetcher_i (
        .clk       (clk),
        .reset     (reset),
        .hdr_done  (hdr_done),
        .sec_tick  (sec_tick),
        .hour      (hour),
        .minute    (minute),
        .second    (second),
        .cr_q      (cr_q),
        .cr_a      (cr_a),
        .row_bits  (row_bits),
        .row_char  (row_char),
        .row_line  (row_line),
        .row_valid (row_valid),
        .row_ready (row_ready)
    );

    pixel_writer pixel_writer_i (
        .clk       (clk),
        .reset     (reset),
        .fb_base   (fb_base),
        .row_bits  (row_bits),
        .row_char  (row_char),
        .row_line  (row_line),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

endmodule

//--- photo_clock_chk.sv
`timescale 1ns/1ps

module photo_clock_chk #(
    parameter bit CHECK_ROWS = 1'b0  // 0 at the image port, 1 at the pixel writer
) (
    input logic clk,
    input logic reset,
    input logic hdr_done,
    input logic wr_en,
    input logic row_valid,
    input logic row_ready
);

    logic       hdr_seen;  // header has been read
    logic [3:0] owed;      // writes still due for the accepted row
    logic       accept;

    assign accept = row_valid && row_ready;

    always_ff @(posedge clk) begin
        if (reset)
            hdr_seen <= 1'b0;
        else if (hdr_done)
            hdr_seen <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            owed <= '0;
        else if (accept)
            owed <= 4'd13;  // one glyph row
        else if (owed != 4'd0)
            owed <= owed - 4'd1;
    end

    if (!CHECK_ROWS) begin : g_port
        no_early_write: assert property (@(posedge clk) disable iff (reset)
            !hdr_seen |-> !wr_en)
            else $error("pixel write issued before the header was read");
    end else begin : g_rows
        valid_held: assert property (@(posedge clk) disable iff (reset)
            row_valid && !row_ready |=> row_valid)
            else $error("row_valid dropped before the row was taken");
        write_run: assert property (@(posedge clk) disable iff (reset)
            wr_en == (owed != 4'd0))
            else $error("wr_en run does not match 13 writes per accepted row");
        no_early_ready: assert property (@(posedge clk) disable iff (reset)
            (owed > 4'd1) |-> !row_ready)
            else $error("row_ready high before the last pixel of the row");
    end

endmodule

// header ordering at the port, handshakes at the writer
bind image_port photo_clock_chk #(.CHECK_ROWS(1'b0)) port_chk_i (
    .clk       (clk),
    .reset     (reset),
    .hdr_done  (hdr_done),
    .wr_en     (wr_en),
    .row_valid (1'b0),
    .row_ready (1'b0)
);

bind pixel_writer photo_clock_chk #(.CHECK_ROWS(1'b1)) row_chk_i (
    .clk       (clk),
    .reset     (reset),
    .hdr_done  (1'b0),
    .wr_en     (wr_en),
    .row_valid (row_valid),
    .row_ready (row_ready)
);

//--- tb_photo_clock.sv
`timescale 1ns/1ps

module tb_photo_clock
    import album_geom_pkg::*;
#(
    parameter int TICKS_PER_SEC = 3000  // must match the tick word in testdata.hex
);

    // overlay geometry as the frame spec gives it
    localparam int CELL_W     = 13;
    localparam int CELL_H     = 24;
    localparam int FRAME_W    = 256;
    localparam int BOX_OFFSET = 232 * 256 + 152;  // row 232, col 152
    localparam int CHARS      = 8;                // hh:mm:ss
    localparam int COLON      = 10;
    localparam int FONT_ROWS  = 11 * CELL_H;      // ten digits plus colon
    localparam int BOX_W      = CHARS * CELL_W;
    localparam int WRITES     = CHARS * CELL_H * CELL_W;  // pixels per redraw
    localparam int MARGIN     = 500;              // extra watchdog cycles
    localparam pixel_t WHITE  = 24'hff_ffff;
    localparam pixel_t BLACK  = 24'h00_0000;

    logic       clk;
    logic       reset;
    pixel_t     im_q;
    glyph_row_t cr_q;
    im_addr_t   im_a;
    pixel_t     im_d;
    logic       im_wen;
    cr_addr_t   cr_a;

    logic [31:0] tdata [0:15];                 // raw words from testdata.hex
    glyph_row_t  font [0:FONT_ROWS-1];         // character rom contents
    logic        box_hit [0:CELL_H*BOX_W-1];   // pixels written this redraw
    pixel_t      hdr_time;
    im_addr_t    fb_addr;
    int          redraws;
    logic        data_ready;
    im_addr_t    im_hold;                      // address latched by the ram
    cr_addr_t    cr_hold;

    photo_clock_top #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) dut_i (
        .clk    (clk),
        .reset  (reset),
        .im_q   (im_q),
        .cr_q   (cr_q),
        .im_a   (im_a),
        .im_d   (im_d),
        .im_wen (im_wen),
        .cr_a   (cr_a)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // header words at 0 and 1, elsewhere a fill tied to the whole address
    function automatic pixel_t image_word(input im_addr_t a);
        if (a == 20'd0)
            return hdr_time;
        if (a == 20'd1)
            return pixel_t'(fb_addr);
        return {4'hc, a};
    endfunction

    task automatic build_font();
        logic [15:0] s;
        s = 16'd47;  // seed
        for (int r = 0; r < FONT_ROWS; r++) begin
            for (int b = CELL_W - 1; b >= 0; b--) begin
                s = lfsr_step(s);  // one step per bit, msb first
                font[r][b] = s[0];
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] time %0t: %s is %0h, expected %0h",
                                $time, what, got, exp));
    endtask

    // synchronous rams, data shows up 2 ns after the edge
    always @(posedge clk) begin
        #2;
        im_q    = image_word(im_hold);
        im_hold = im_a;
        cr_q    = (int'(cr_hold) < FONT_ROWS) ? font[cr_hold] : '0;
        cr_hold = cr_a;
    end

    // port idle, then reads of address 0 and 1
    task automatic check_header();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("im_wen during header", 32'(im_wen), 32'd1);
            if (i < 2)
                check_value("header read address", 32'(im_a), 32'(i));
        end
    endtask

    task automatic check_redraw(input int r);
        logic [31:0] exp_word;
        int          k;
        int          row;
        int          col;
        int          chr;
        int          line;
        int          glyph;
        int          off;
        int          idx;
        im_addr_t    exp_addr;
        pixel_t      exp_pix;
        exp_word = tdata[4 + r];  // eight glyph nibbles
        check_value("colon slot 2 in testdata", 32'(exp_word[23:20]), 32'(COLON));
        check_value("colon slot 5 in testdata", 32'(exp_word[11:8]), 32'(COLON));
        for (int i = 0; i < CELL_H * BOX_W; i++)
            box_hit[i] = 1'b0;
        k = 0;
        while (k < WRITES) begin
            @(negedge clk);
            if (im_wen === 1'b0) begin
                row  = k / CELL_W;
                col  = k % CELL_W;
                chr  = row / CELL_H;  // char outer, line inner
                line = row % CELL_H;
                // colon slots are fixed, the digits come from the file
                glyph = (chr == 2 || chr == 5) ? COLON : int'(exp_word[31 - 4*chr -: 4]);
                off = int'(im_a) - int'(fb_addr) - BOX_OFFSET;
                if (off < 0 || off % FRAME_W >= BOX_W || off / FRAME_W >= CELL_H)
                    abort_run($sformatf("[ERROR] time %0t: write at %0h lies outside the text box",
                                        $time, im_a));
                idx = (off / FRAME_W) * BOX_W + off % FRAME_W;
                if (box_hit[idx])
                    abort_run($sformatf("[ERROR] time %0t: address %0h written twice in one redraw",
                                        $time, im_a));
                box_hit[idx] = 1'b1;
                exp_addr = fb_addr + im_addr_t'(BOX_OFFSET + chr*CELL_W + line*FRAME_W + col);
                check_value("write address", 32'(im_a), 32'(exp_addr));
                exp_pix = font[glyph*CELL_H + line][CELL_W-1-col] ? WHITE : BLACK;
                check_value("pixel colour", 32'(im_d), 32'(exp_pix));
                k++;
            end
        end
        $display("redraw %0d shows %02h:%02h:%02h", r,
                 exp_word[31:24], exp_word[19:12], exp_word[7:0]);
    endtask

    // budget: one second per redraw plus one, and some slack
    initial begin
        wait (data_ready === 1'b1);
        repeat ((redraws + 1) * TICKS_PER_SEC + MARGIN) @(posedge clk);
        abort_run("timeout: the DUT did not finish all redraws in time");
    end

    initial begin
        reset      = 1'b1;
        im_q       = '0;
        cr_q       = '0;
        im_hold    = '0;
        cr_hold    = '0;
        data_ready = 1'b0;
        $readmemh("testdata.hex", tdata);
        hdr_time = tdata[0][23:0];
        fb_addr  = tdata[1][19:0];
        redraws  = int'(tdata[3]);
        if ($isunknown(tdata[3]) || redraws < 1 || redraws > 12)
            abort_run("testdata.hex is missing or holds no valid redraw count");
        if (tdata[2] !== 32'(TICKS_PER_SEC))
            abort_run("tick length in testdata.hex does not match TICKS_PER_SEC");
        build_font();
        data_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("im_wen in reset", 32'(im_wen), 32'd1);
        check_value("im_a in reset", 32'(im_a), 32'd0);
        @(posedge clk);  // fifth reset cycle
        #2 reset = 1'b0;
        check_header();
        for (int r = 0; r < redraws; r++)
            check_redraw(r);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- testdata.hex
// words: start time hhmmss, frame buffer base, ticks per second, redraw count
// then one word per redraw, eight glyph nibbles h h a m m a s s (a = colon)
00173b3a
00010000
00000bb8
00000003
23a59a58
23a59a59
00a00a00

//--- compile.f
album_geom_pkg.sv
album_time_pkg.sv
image_port.sv
rtc_counter.sv
glyph_fetcher.sv
pixel_writer.sv
photo_clock_top.sv
photo_clock_chk.sv
tb_photo_clock.sv

//--- Makefile
# Verilator build for the photo clock overlay testbench

VERILATOR ?= verilator
TOP       ?= tb_photo_clock
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
